//--- src/cart_loader_pkg.sv
// Cartridge loader shared types, records and header layout constants
package cart_loader_pkg;

	// ========================================
	// Plain vector types
	// ========================================
	typedef logic [24:0] load_addr_t;
	typedef logic [15:0] load_data_t;
	typedef logic [7:0]  load_index_t;
	typedef logic [23:0] mem_mask_t;
	typedef logic [7:0]  rom_type_t;
	typedef logic [3:0]  size_code_t;
	typedef logic [31:0] sd_lba_t;

	// Header mode as chosen in the menu
	typedef enum logic [2:0] {
		hdr_auto    = 3'd0,
		hdr_none    = 3'd1,
		hdr_lorom   = 3'd2,
		hdr_hirom   = 3'd3,
		hdr_exhirom = 3'd4
	} header_mode_t;

	// ========================================
	// Grouped records
	// ========================================
	typedef struct packed {
		load_addr_t addr;
		load_data_t data;
		logic       is_code;
	} load_word_t;

	typedef struct packed {
		rom_type_t rom_type;
		mem_mask_t rom_mask;
		mem_mask_t ram_mask;
		logic      region;
	} cart_info_t;

	// Big endian words, same order as the cheat file
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		sd_lba_t lba;
		logic    rd;
		logic    wr;
	} sd_req_t;

	typedef enum logic [1:0] {
		bk_idle,
		bk_wait_ack,
		bk_wait_release
	} backup_state_t;

	// ========================================
	// Header layout
	// ========================================
	// Copier header in front of the ROM image
	localparam int unsigned HEADER_OFFSET = 512;
	localparam size_code_t DEFAULT_ROM_SIZE = 4'd12;
	localparam load_addr_t LOROM_SIZE_ADDR = load_addr_t'(25'h7FD6 + HEADER_OFFSET);
	localparam load_addr_t LOROM_RAM_ADDR = load_addr_t'(25'h7FD8 + HEADER_OFFSET);
	localparam load_addr_t HIROM_SIZE_ADDR = load_addr_t'(25'hFFD6 + HEADER_OFFSET);
	localparam load_addr_t HIROM_RAM_ADDR = load_addr_t'(25'hFFD8 + HEADER_OFFSET);
	localparam load_addr_t EXHIROM_SIZE_ADDR = load_addr_t'(25'h40FFD6 + HEADER_OFFSET);
	localparam load_addr_t EXHIROM_RAM_ADDR = load_addr_t'(25'h40FFD8 + HEADER_OFFSET);
	localparam load_addr_t REGION_ADDR = 25'd2;
	localparam mem_mask_t MASK_BASE = 24'd1024;
	localparam int unsigned BLOCK_SHIFT = 9;
	localparam logic [3:0] CHEAT_LAST_OFFSET = 4'd14;

endpackage

//--- src/load_word_decoder.sv
// Download word decoder: registers accepted words, tags code files, flags cart start and end
`timescale 1ns/1ps

module load_word_decoder (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         dl_active,
	input  cart_loader_pkg::load_index_t dl_index,
	input  logic                         dl_valid,
	input  cart_loader_pkg::load_word_t  dl_word,
	output logic                         dl_ready,
	input  logic                         busy,
	output logic                         word_valid,
	output cart_loader_pkg::load_word_t  word,
	output logic                         cart_active,
	output logic                         cart_start,
	output logic                         cart_end
);

	logic code_index;
	logic cart_level;
	logic accept;

	// All index bits set selects the cheat file
	assign code_index = &dl_index;
	assign cart_level = dl_active & ~code_index;

	// Source must hold its word while a backup transfer runs
	assign dl_ready = ~busy;
	assign accept   = dl_valid & dl_ready;

	// Payload stage
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			word.addr    <= dl_word.addr;
			word.data    <= dl_word.data;
			word.is_code <= code_index;
		end
	end

	// cart_active doubles as the previous level for edge detection
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			word_valid  <= 1'b0;
			cart_active <= 1'b0;
			cart_start  <= 1'b0;
			cart_end    <= 1'b0;
		end else begin
			word_valid  <= accept;
			cart_active <= cart_level;
			cart_start  <= cart_level & ~cart_active;
			cart_end    <= ~cart_level & cart_active;
		end
	end

endmodule

//--- src/cart_header_parser.sv
// Cartridge header parser: ROM type, ROM and save RAM masks, video region
`timescale 1ns/1ps

module cart_header_parser (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          word_valid,
	input  cart_loader_pkg::load_word_t   word,
	input  cart_loader_pkg::header_mode_t header_mode,
	output cart_loader_pkg::cart_info_t   cart_info
);

	cart_loader_pkg::size_code_t rom_size;
	cart_loader_pkg::size_code_t ram_size;
	cart_loader_pkg::size_code_t rom_size_next;
	cart_loader_pkg::size_code_t ram_size_next;
	cart_loader_pkg::cart_info_t info_next;
	logic                        cart_word;

	// 1 KB shifted by the log2 size code
	function automatic cart_loader_pkg::mem_mask_t size_to_mask(
		input cart_loader_pkg::size_code_t size
	);
		return (cart_loader_pkg::MASK_BASE << size) - 1'b1;
	endfunction

	assign cart_word = word_valid & ~word.is_code;

	// ========================================
	// Next header values
	// ========================================
	always_comb begin
		rom_size_next = rom_size;
		ram_size_next = ram_size;
		info_next     = cart_info;

		if (word.addr == '0) begin
			rom_size_next = cart_loader_pkg::DEFAULT_ROM_SIZE;
			ram_size_next = '0;
			if (header_mode == cart_loader_pkg::hdr_auto && word.data[7:0] != '0) begin
				{ram_size_next, rom_size_next} = word.data[7:0];
			end
			case (header_mode)
				cart_loader_pkg::hdr_none:    info_next.rom_type = 8'd0;
				cart_loader_pkg::hdr_lorom:   info_next.rom_type = 8'd0;
				cart_loader_pkg::hdr_hirom:   info_next.rom_type = 8'd1;
				cart_loader_pkg::hdr_exhirom: info_next.rom_type = 8'd2;
				default:                      info_next.rom_type = word.data[15:8];
			endcase
		end

		if (word.addr == cart_loader_pkg::REGION_ADDR) begin
			info_next.region = word.data[8];
		end

		// Size bytes sit at fixed places in each mapping
		case (header_mode)
			cart_loader_pkg::hdr_lorom: begin
				if (word.addr == cart_loader_pkg::LOROM_SIZE_ADDR) rom_size_next = word.data[11:8];
				if (word.addr == cart_loader_pkg::LOROM_RAM_ADDR) ram_size_next = word.data[3:0];
			end
			cart_loader_pkg::hdr_hirom: begin
				if (word.addr == cart_loader_pkg::HIROM_SIZE_ADDR) rom_size_next = word.data[11:8];
				if (word.addr == cart_loader_pkg::HIROM_RAM_ADDR) ram_size_next = word.data[3:0];
			end
			cart_loader_pkg::hdr_exhirom: begin
				if (word.addr == cart_loader_pkg::EXHIROM_SIZE_ADDR) rom_size_next = word.data[11:8];
				if (word.addr == cart_loader_pkg::EXHIROM_RAM_ADDR) ram_size_next = word.data[3:0];
			end
			default: ;
		endcase

		info_next.rom_mask = size_to_mask(rom_size_next);
		info_next.ram_mask = (ram_size_next != '0) ? size_to_mask(ram_size_next) : '0;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size  <= '0;
			ram_size  <= '0;
			cart_info <= '0;
		end else if (cart_word) begin
			rom_size  <= rom_size_next;
			ram_size  <= ram_size_next;
			cart_info <= info_next;
		end
	end

endmodule

//--- src/cheat_code_assembler.sv
// Cheat code assembler: collects eight half-words into one 128-bit record
`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         word_valid,
	input  cart_loader_pkg::load_word_t  word,
	output cart_loader_pkg::cheat_code_t code,
	output logic                         code_valid,
	output logic                         code_clear
);

	cart_loader_pkg::load_addr_t code_addr;
	logic                        code_word;

	// Code files carry the same copier header as ROMs
	assign code_addr = word.addr - cart_loader_pkg::load_addr_t'(cart_loader_pkg::HEADER_OFFSET);
	assign code_word = word_valid & word.is_code;

	// Record fields, low half-word first
	always_ff @(posedge clk_sys) begin
		if (code_word) begin
			case (code_addr[3:0])
				4'd0:  code.flags[15:0]    <= word.data;
				4'd2:  code.flags[31:16]   <= word.data;
				4'd4:  code.address[15:0]  <= word.data;
				4'd6:  code.address[31:16] <= word.data;
				4'd8:  code.compare[15:0]  <= word.data;
				4'd10: code.compare[31:16] <= word.data;
				4'd12: code.replace[15:0]  <= word.data;
				cart_loader_pkg::CHEAT_LAST_OFFSET: code.replace[31:16] <= word.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			code_valid <= 1'b0;
			code_clear <= 1'b0;
		end else begin
			code_valid <= code_word && code_addr[3:0] == cart_loader_pkg::CHEAT_LAST_OFFSET;
			// New code file or any cartridge load drops the old codes
			code_clear <= word_valid & (~word.is_code | (word.addr == '0));
		end
	end

endmodule

//--- src/backup_sequencer.sv
// Backup RAM sequencer: block-wise SD reads or writes of the save RAM image
`timescale 1ns/1ps

module backup_sequencer (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        cart_active,
	input  logic                        cart_start,
	input  logic                        cart_end,
	input  cart_loader_pkg::cart_info_t cart_info,
	input  logic                        img_mounted,
	input  logic                        img_readonly,
	input  logic                        img_has_data,
	input  logic                        load_req,
	input  logic                        save_req,
	input  logic                        sd_ack,
	output cart_loader_pkg::sd_req_t    sd_req,
	output logic                        busy
);

	cart_loader_pkg::backup_state_t state;
	cart_loader_pkg::sd_lba_t       last_lba;
	logic                           enable;
	logic                           loading;
	logic                           load_prev;
	logic                           save_prev;
	logic                           load_rise;
	logic                           save_rise;

	assign load_rise = load_req & ~load_prev & enable;
	assign save_rise = save_req & ~save_prev & enable;
	assign last_lba  = cart_loader_pkg::sd_lba_t'(cart_info.ram_mask >> cart_loader_pkg::BLOCK_SHIFT);
	assign busy      = (state != cart_loader_pkg::bk_idle);

	// ========================================
	// Save image enable
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			enable    <= 1'b0;
			load_prev <= 1'b0;
			save_prev <= 1'b0;
		end else begin
			load_prev <= load_req;
			save_prev <= save_req;
			if (cart_start) enable <= 1'b0;
			// Image is mounted by the time the cartridge download runs
			if (cart_active && img_mounted && !img_readonly) enable <= |cart_info.ram_mask;
		end
	end

	// ========================================
	// Block transfer FSM
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state      <= cart_loader_pkg::bk_idle;
			loading    <= 1'b0;
			sd_req.lba <= '0;
			sd_req.rd  <= 1'b0;
			sd_req.wr  <= 1'b0;
		end else begin
			case (state)
				cart_loader_pkg::bk_idle: begin
					if (load_rise | save_rise) begin
						state      <= cart_loader_pkg::bk_wait_ack;
						loading    <= load_rise;
						sd_req.lba <= '0;
						sd_req.rd  <= load_rise;
						sd_req.wr  <= ~load_rise;
					end
					// Pull the save file in once the ROM is loaded
					if (cart_end && img_has_data && enable) begin
						state      <= cart_loader_pkg::bk_wait_ack;
						loading    <= 1'b1;
						sd_req.lba <= '0;
						sd_req.rd  <= 1'b1;
						sd_req.wr  <= 1'b0;
					end
				end
				cart_loader_pkg::bk_wait_ack: begin
					if (sd_ack) begin
						state     <= cart_loader_pkg::bk_wait_release;
						sd_req.rd <= 1'b0;
						sd_req.wr <= 1'b0;
					end
				end
				cart_loader_pkg::bk_wait_release: begin
					// Block done on the falling edge of ack
					if (!sd_ack) begin
						if (sd_req.lba >= last_lba) begin
							state   <= cart_loader_pkg::bk_idle;
							loading <= 1'b0;
						end else begin
							state      <= cart_loader_pkg::bk_wait_ack;
							sd_req.lba <= sd_req.lba + 1'b1;
							sd_req.rd  <= loading;
							sd_req.wr  <= ~loading;
						end
					end
				end
				default: state <= cart_loader_pkg::bk_idle;
			endcase
		end
	end

endmodule

//--- src/cart_loader_top.sv
// Cartridge loader top: decode, header and cheat stages, backup RAM sequencer
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          dl_active,
	input  cart_loader_pkg::load_index_t  dl_index,
	input  logic                          dl_valid,
	input  cart_loader_pkg::load_word_t   dl_word,
	output logic                          dl_ready,
	input  cart_loader_pkg::header_mode_t header_mode,
	input  logic                          img_mounted,
	input  logic                          img_readonly,
	input  logic                          img_has_data,
	input  logic                          load_req,
	input  logic                          save_req,
	input  logic                          sd_ack,
	output cart_loader_pkg::cart_info_t   cart_info,
	output cart_loader_pkg::cheat_code_t  code,
	output logic                          code_valid,
	output logic                          code_clear,
	output cart_loader_pkg::sd_req_t      sd_req,
	output logic                          busy
);

	logic                        word_valid;
	cart_loader_pkg::load_word_t word;
	logic                        cart_active;
	logic                        cart_start;
	logic                        cart_end;

	load_word_decoder u_decoder (.clk_sys, .reset, .dl_active, .dl_index, .dl_valid,
		.dl_word, .dl_ready, .busy, .word_valid, .word, .cart_active, .cart_start,
		.cart_end);

	cart_header_parser u_parser (.clk_sys, .reset, .word_valid, .word, .header_mode,
		.cart_info);

	cheat_code_assembler u_cheats (.clk_sys, .reset, .word_valid, .word, .code,
		.code_valid, .code_clear);

	backup_sequencer u_backup (.clk_sys, .reset, .cart_active, .cart_start, .cart_end,
		.cart_info, .img_mounted, .img_readonly, .img_has_data, .load_req, .save_req,
		.sd_ack, .sd_req, .busy);

endmodule

//--- testbench/tb_cart_loader.sv
// Cartridge loader testbench for header decode, cheat records and backup RAM transfers
`timescale 1ns/1ps

module tb_cart_loader;

	localparam int NUM_TESTS       = 6;
	localparam int EXPECTED_BLOCKS = 8;
	localparam int TIMEOUT_CYCLES  = 200 * NUM_TESTS + 40 * EXPECTED_BLOCKS;

	logic clk_sys;
	logic reset;
	logic dl_active;
	logic dl_valid;
	logic dl_ready;
	logic img_mounted;
	logic img_readonly;
	logic img_has_data;
	logic load_req;
	logic save_req;
	logic sd_ack;
	logic code_valid;
	logic code_clear;
	logic busy;
	cart_loader_pkg::load_index_t  dl_index;
	cart_loader_pkg::load_word_t   dl_word;
	cart_loader_pkg::header_mode_t header_mode;
	cart_loader_pkg::cart_info_t   cart_info;
	cart_loader_pkg::cheat_code_t  code;
	cart_loader_pkg::sd_req_t      sd_req;

	integer  seed = 89469;
	int      ack_delay;
	int      word_count;
	int      valid_count;
	int      clear_count;
	bit      busy_seen;
	string   test_name;
	cart_loader_pkg::sd_lba_t lba_log[$];
	bit      read_log[$];

	cart_loader_top uut (.clk_sys, .reset, .dl_active, .dl_index, .dl_valid, .dl_word,
		.dl_ready, .header_mode, .img_mounted, .img_readonly, .img_has_data, .load_req,
		.save_req, .sd_ack, .cart_info, .code, .code_valid, .code_clear, .sd_req, .busy);

	always #5 clk_sys = ~clk_sys;

	// ========================================
	// Helpers and compare tasks
	// ========================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_info(input string what, input cart_loader_pkg::cart_info_t exp,
		input cart_loader_pkg::cart_info_t act);
		if (exp !== act) begin
			$display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
			abort_run("Header info mismatch");
		end
	endtask

	task automatic check_code(input string what, input cart_loader_pkg::cheat_code_t exp,
		input cart_loader_pkg::cheat_code_t act);
		if (exp !== act) begin
			$display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
			abort_run("Cheat record mismatch");
		end
	endtask

	task automatic check_lba(input string what, input cart_loader_pkg::sd_lba_t exp,
		input cart_loader_pkg::sd_lba_t act);
		if (exp !== act) begin
			$display("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act);
			abort_run("SD block number mismatch");
		end
	endtask

	task automatic compare_count(input string what, input int exp, input int act);
		if (exp !== act) begin
			$display("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act);
			abort_run("Count mismatch");
		end
	endtask

	// Mask of a 2^code KB region
	function automatic cart_loader_pkg::mem_mask_t rom_mask_for(input int code_val);
		return cart_loader_pkg::mem_mask_t'((32'd1 << (code_val + 10)) - 32'd1);
	endfunction

	function automatic cart_loader_pkg::mem_mask_t ram_mask_for(input int code_val);
		return (code_val == 0) ? '0 : rom_mask_for(code_val);
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic start_download(input cart_loader_pkg::load_index_t index,
		input cart_loader_pkg::header_mode_t mode);
		header_mode = mode;
		dl_index    = index;
		dl_active   = 1'b1;
		wait_cycles(1);
	endtask

	task automatic finish_download();
		wait_cycles(4);
		dl_active = 1'b0;
		dl_index  = '0;
		wait_cycles(3);
	endtask

	task automatic send_word(input cart_loader_pkg::load_addr_t addr,
		input cart_loader_pkg::load_data_t data);
		dl_word  = '{addr: addr, data: data, is_code: 1'b0};
		dl_valid = 1'b1;
		@(negedge clk_sys);
		while (!dl_ready) @(negedge clk_sys);
		wait_cycles(1);
		dl_valid = 1'b0;
	endtask

	task automatic pulse_save();
		save_req = 1'b1;
		wait_cycles(2);
		save_req = 1'b0;
	endtask

	task automatic wait_for_idle();
		while (!busy) @(negedge clk_sys);
		while (busy) @(negedge clk_sys);
		wait_cycles(1);
	endtask

	task automatic verify_transfer(input int blocks, input bit is_read);
		compare_count("block count", blocks, lba_log.size());
		for (int i = 0; i < blocks; i++) begin
			check_lba("lba", cart_loader_pkg::sd_lba_t'(i), lba_log[i]);
			compare_count("read direction", int'(is_read), int'(read_log[i]));
		end
		lba_log.delete();
		read_log.delete();
	endtask

	// ========================================
	// Directed tests
	// ========================================
	task automatic auto_header_decode();
		cart_loader_pkg::cart_info_t exp;
		test_name = "auto_header";
		exp = '{rom_type: 8'h21, rom_mask: rom_mask_for(3), ram_mask: ram_mask_for(2),
			region: 1'b0};
		start_download(8'h00, cart_loader_pkg::hdr_auto);
		send_word('0, 16'h2123);
		wait_cycles(2);
		check_info("cart_info", exp, cart_info);
		finish_download();
	endtask

	task automatic mapped_header_decode();
		cart_loader_pkg::cart_info_t exp;
		test_name = "lorom_header";
		exp = '{rom_type: 8'd0, rom_mask: rom_mask_for(10), ram_mask: ram_mask_for(3),
			region: 1'b1};
		start_download(8'h00, cart_loader_pkg::hdr_lorom);
		clear_count = 0;
		send_word('0, 16'h5A5A);
		send_word(cart_loader_pkg::REGION_ADDR, 16'h0100);
		send_word(cart_loader_pkg::LOROM_SIZE_ADDR, 16'h0A00);
		send_word(cart_loader_pkg::LOROM_RAM_ADDR, 16'h0003);
		wait_cycles(2);
		check_info("cart_info", exp, cart_info);
		wait_cycles(1);
		// Every cartridge word drops the cheat codes
		compare_count("code_clear pulses", 4, clear_count);
		finish_download();
		test_name = "exhirom_header";
		exp = '{rom_type: 8'd2, rom_mask: rom_mask_for(11), ram_mask: ram_mask_for(5),
			region: 1'b0};
		start_download(8'h00, cart_loader_pkg::hdr_exhirom);
		send_word('0, 16'h0000);
		send_word(cart_loader_pkg::REGION_ADDR, 16'h0000);
		send_word(cart_loader_pkg::EXHIROM_SIZE_ADDR, 16'h0B00);
		send_word(cart_loader_pkg::EXHIROM_RAM_ADDR, 16'h0005);
		wait_cycles(2);
		check_info("cart_info", exp, cart_info);
		finish_download();
	endtask

	task automatic cheat_record_assembly();
		cart_loader_pkg::cheat_code_t exp;
		logic [127:0] flat;
		logic [31:0]  field;
		test_name = "cheat_code";
		exp = '{flags: 32'h8000_00A1, address: 32'h007E_1234, compare: 32'h0000_0055,
			replace: 32'hC0DE_00FF};
		flat = exp;
		start_download(8'hFF, cart_loader_pkg::hdr_auto);
		clear_count = 0;
		valid_count = 0;
		send_word('0, 16'hDEAD);
		wait_cycles(3);
		compare_count("code_clear pulses", 1, clear_count);
		// Offsets 0 to 14 with the low half-word of each field first
		for (int i = 0; i < 8; i++) begin
			field = flat[127 - 32 * (i / 2) -: 32];
			send_word(cart_loader_pkg::load_addr_t'(cart_loader_pkg::HEADER_OFFSET + 2 * i),
				(i % 2 == 1) ? field[31:16] : field[15:0]);
		end
		wait_cycles(3);
		compare_count("code_valid pulses", 1, valid_count);
		compare_count("code_clear pulses", 1, clear_count);
		check_code("code", exp, code);
		finish_download();
	endtask

	task automatic load_after_cart();
		test_name = "load_after_cart";
		img_mounted  = 1'b1;
		img_readonly = 1'b0;
		img_has_data = 1'b1;
		start_download(8'h00, cart_loader_pkg::hdr_auto);
		send_word('0, 16'h0414);
		finish_download();
		wait_for_idle();
		verify_transfer(int'(ram_mask_for(1) >> 9) + 1, 1'b1);
		img_has_data = 1'b0;
	endtask

	task automatic save_with_stalled_download();
		test_name = "save_stall";
		pulse_save();
		while (!busy) @(negedge clk_sys);
		wait_cycles(1);
		// Code file word at an odd offset leaves the record untouched
		dl_index   = 8'hFF;
		dl_active  = 1'b1;
		word_count = 0;
		dl_word    = '{addr: 25'd513, data: 16'h1234, is_code: 1'b0};
		dl_valid   = 1'b1;
		while (busy) @(negedge clk_sys);
		compare_count("words taken while busy", 0, word_count);
		while (!dl_ready) @(negedge clk_sys);
		wait_cycles(1);
		dl_valid = 1'b0;
		wait_cycles(2);
		compare_count("words taken after busy", 1, word_count);
		verify_transfer(int'(ram_mask_for(1) >> 9) + 1, 1'b0);
		finish_download();
	endtask

	task automatic save_without_backup();
		test_name = "save_no_ram";
		busy_seen = 1'b0;
		start_download(8'h00, cart_loader_pkg::hdr_auto);
		send_word('0, 16'h0004);
		finish_download();
		pulse_save();
		wait_cycles(30);
		compare_count("requests", 0, lba_log.size());
		compare_count("busy seen", 0, int'(busy_seen));
		test_name = "save_readonly";
		img_readonly = 1'b1;
		start_download(8'h00, cart_loader_pkg::hdr_auto);
		send_word('0, 16'h0014);
		finish_download();
		pulse_save();
		wait_cycles(30);
		compare_count("requests", 0, lba_log.size());
		compare_count("busy seen", 0, int'(busy_seen));
	endtask

	// ========================================
	// SD responder, monitor and watchdog
	// ========================================
	initial begin
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (sd_req.rd || sd_req.wr) begin
				if (sd_req.rd && sd_req.wr) abort_run("SD request has both read and write set");
				lba_log.push_back(sd_req.lba);
				read_log.push_back(sd_req.rd);
				ack_delay = 1 + ($unsigned($random(seed)) % 4);
				wait_cycles(ack_delay);
				sd_ack = 1'b1;
				wait_cycles(3);
				sd_ack = 1'b0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (uut.word_valid) word_count++;
		if (code_valid) valid_count++;
		if (code_clear) clear_count++;
		if (busy) busy_seen = 1'b1;
		if (busy && dl_ready) abort_run("dl_ready is high while a backup transfer runs");
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_sys);
		abort_run("Watchdog timeout, the tests did not finish in time");
	end

	initial begin
		clk_sys      = 1'b0;
		reset        = 1'b0;
		dl_active    = 1'b0;
		dl_index     = '0;
		dl_valid     = 1'b0;
		dl_word      = '0;
		header_mode  = cart_loader_pkg::hdr_auto;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_has_data = 1'b0;
		load_req     = 1'b0;
		save_req     = 1'b0;
		word_count   = 0;
		valid_count  = 0;
		clear_count  = 0;
		busy_seen    = 1'b0;
		wait_cycles(2);
		reset = 1'b1;
		wait_cycles(2);
		auto_header_decode();
		mapped_header_decode();
		cheat_record_assembly();
		load_after_cart();
		save_with_stalled_download();
		save_without_backup();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- files.f
src/cart_loader_pkg.sv
src/load_word_decoder.sv
src/cart_header_parser.sv
src/cheat_code_assembler.sv
src/backup_sequencer.sv
src/cart_loader_top.sv
testbench/tb_cart_loader.sv

//--- Bender.yml
package:
  name: cart_loader

sources:
  - files:
      - src/cart_loader_pkg.sv
      - src/load_word_decoder.sv
      - src/cart_header_parser.sv
      - src/cheat_code_assembler.sv
      - src/backup_sequencer.sv
      - src/cart_loader_top.sv
  - target: test
    files:
      - testbench/tb_cart_loader.sv
